// File: Makefile
TOP := system_controller_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

# Passes only when the testbench prints its pass line
test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: bench/result_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "bnn_params.svh"

module result_checker (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       SCLK,
  input  logic       COPI,
  input  logic       spi_cs_n,
  input  logic [3:0] result_out,
  input  logic       result_ready,
  input  logic       send_image,
  input  logic       status_ready,
  input  logic       heartbeat,
  input  logic [2:0] test_id,
  output int         error_count,
  output int         check_count
);

  // Pin-level copy of the image buffer
  logic [7:0] model_mem [`IMG_BYTES];
  int         model_cnt;
  // Frame decoder state
  logic       sclk_prev;
  logic       cs_prev;
  logic       first_byte;
  logic [3:0] cur_op;
  logic [7:0] shift;
  int         bit_cnt;
  // Expected pin levels
  logic       exp_ready;
  int         exp_out;
  int         exp_class;
  logic       pending;
  logic       after_reset;
  int         wait_cnt;
  // Countdown from chip select rising to the level checks
  int         settle;
  // Cycles since reset, top bit is the expected heartbeat
  logic [`HEARTBEAT_BITS-1:0] hb_model;

  function automatic string test_label(input logic [2:0] id);
    case (id)
      3'd1: return "reset";
      3'd2: return "full_classify";
      3'd3: return "partial_classify";
      3'd4: return "overfill";
      3'd5: return "clear_reload";
      3'd6: return "aborted_frame";
      default: return "unknown";
    endcase
  endfunction

  // Pixel by pixel agreement, first class kept on a tie
  function automatic int model_argmax();
    int best;
    int best_score;
    int score;
    logic [7:0] w;
    best = 0;
    best_score = -1;
    for (int c = 0; c < `NUM_CLASSES; c++) begin
      score = 0;
      for (int i = 0; i < `IMG_BYTES; i++) begin
        w = 8'((i * 37 + c * 101) % 256) ^ 8'h5A;
        for (int k = 0; k < 8; k++) begin
          if (model_mem[i][k] == w[k]) begin
            score++;
          end
        end
      end
      if (score > best_score) begin
        best_score = score;
        best = c;
      end
    end
    return best;
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    check_count++;
    if (expected != actual) begin
      error_count++;
      $display("ERR %s: %s expected %0d actual %0d",
               test_label(test_id), what, expected, actual);
    end
  endtask

  task automatic report_failure(input string text);
    error_count++;
    $display("%s: %s", test_label(test_id), text);
  endtask

  task automatic clear_model();
    for (int i = 0; i < `IMG_BYTES; i++) begin
      model_mem[i] = 8'h00;
    end
    model_cnt = 0;
  endtask

  // One complete byte seen on the pins
  task automatic take_model_byte(input logic [7:0] b);
    if (first_byte) begin
      first_byte = 1'b0;
      cur_op = b[7:4];
      if (cur_op == `OP_LOAD) begin
        exp_ready = 1'b0;
      end else if (cur_op == `OP_CLASSIFY && model_cnt == `IMG_BYTES) begin
        pending = 1'b1;
        wait_cnt = 0;
        exp_class = model_argmax();
      end else if (cur_op == `OP_CLEAR) begin
        clear_model();
        exp_ready = 1'b0;
      end
    end else if (cur_op == `OP_LOAD && model_cnt < `IMG_BYTES) begin
      model_mem[model_cnt] = b;
      model_cnt++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      clear_model();
      sclk_prev   = 1'b0;
      cs_prev     = 1'b1;
      first_byte  = 1'b1;
      cur_op      = 4'd0;
      shift       = 8'd0;
      bit_cnt     = 0;
      exp_ready   = 1'b0;
      exp_out     = 0;
      exp_class   = 0;
      pending     = 1'b0;
      after_reset = 1'b1;
      wait_cnt    = 0;
      settle      = 0;
      hb_model    = '0;
    end else begin
      // Reset levels, first cycle out of reset
      if (after_reset) begin
        check_value("send_image", 1, int'(send_image));
        check_value("status_ready", 1, int'(status_ready));
        check_value("result_ready", 0, int'(result_ready));
        check_value("result_out", 0, int'(result_out));
        after_reset = 1'b0;
      end
      // Heartbeat follows a free-running counter from reset
      check_value("heartbeat", int'(hb_model[`HEARTBEAT_BITS-1]), int'(heartbeat));
      hb_model = hb_model + 1'b1;
      // Frame decode, partial byte dropped when chip select rises
      if (spi_cs_n) begin
        bit_cnt = 0;
        first_byte = 1'b1;
        if (!cs_prev) begin
          settle = 6;
        end
      end else if (SCLK && !sclk_prev) begin
        shift = {shift[6:0], COPI};
        bit_cnt++;
        if (bit_cnt == 8) begin
          take_model_byte(shift);
          bit_cnt = 0;
        end
      end
      // FSM back in IDLE by now
      if (settle > 0) begin
        settle--;
        if (settle == 0 && !pending) begin
          check_value("result_ready", int'(exp_ready), int'(result_ready));
          check_value("result_out", exp_out, int'(result_out));
          check_value("send_image", int'(model_cnt == 0), int'(send_image));
          check_value("status_ready", 1, int'(status_ready));
        end
      end
      // Inference in flight, status_ready marks the end
      if (pending) begin
        wait_cnt++;
        if (status_ready) begin
          if (wait_cnt < 1130) begin
            report_failure("status_ready returned before inference could finish");
          end
          check_value("result_ready", 1, int'(result_ready));
          check_value("result_out", exp_class, int'(result_out));
          exp_out = exp_class;
          exp_ready = 1'b1;
          pending = 1'b0;
        end else if (wait_cnt > 1300) begin
          report_failure("no result within 1300 cycles of the classify command");
          pending = 1'b0;
        end
      end
      sclk_prev = SCLK;
      cs_prev = spi_cs_n;
    end
  end

endmodule

`default_nettype wire

// File: bench/system_controller_sva.sv
`timescale 1ns/10ps
`default_nettype none

module system_controller_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                bnn_start,
  input logic                byte_taken,
  input logic                buf_full,
  input logic                status_ready,
  input bnn_pkg::fsm_state_e fsm_state
);

  // Read by the testbench at the end of the run
  int fail_count = 0;

  // Start strobe is one cycle wide
  start_pulse: assert property (@(posedge clk) disable iff (!rst_n) bnn_start |=> !bnn_start)
    else begin
      fail_count++;
      $error("bnn_start high for more than one cycle");
    end

  // Take strobe is one cycle wide
  take_pulse: assert property (@(posedge clk) disable iff (!rst_n) byte_taken |=> !byte_taken)
    else begin
      fail_count++;
      $error("byte_taken high for more than one cycle");
    end

  // Inference only on a complete image
  start_full: assert property (@(posedge clk) disable iff (!rst_n) bnn_start |-> buf_full)
    else begin
      fail_count++;
      $error("bnn_start while the image buffer is not full");
    end

  run_busy: assert property (@(posedge clk) disable iff (!rst_n)
                             (fsm_state == bnn_pkg::RUN) |-> !status_ready)
    else begin
      fail_count++;
      $error("status_ready high during RUN");
    end

endmodule

bind controller_fsm system_controller_sva u_fsm_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .bnn_start    (bnn_start),
  .byte_taken   (byte_taken),
  .buf_full     (status.full),
  .status_ready (status_ready),
  .fsm_state    (fsm_state)
);

`default_nettype wire

// File: bench/system_controller_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "bnn_params.svh"

module system_controller_tb;

  // 20 sessions of the longest frame plus 20 inferences
  localparam int WATCHDOG_CYCLES = 20 * 114 * 8 * 14 + 20 * 1200;
  // Inference is about 1135 cycles from the command byte
  localparam int RESULT_TIMEOUT = 2000;

  logic       clk;
  logic       rst_n;
  logic       SCLK;
  logic       COPI;
  logic       spi_cs_n;
  logic [3:0] result_out;
  logic       result_ready;
  logic       send_image;
  logic       status_ready;
  logic       heartbeat;
  logic [2:0] test_id;
  int         chk_errors;
  int         chk_checks;
  int         tb_errors;
  int         sva_fails;

  system_controller UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .SCLK         (SCLK),
    .COPI         (COPI),
    .spi_cs_n     (spi_cs_n),
    .result_out   (result_out),
    .result_ready (result_ready),
    .send_image   (send_image),
    .status_ready (status_ready),
    .heartbeat    (heartbeat)
  );

  // Decodes the SPI pins on its own and compares the status pins
  result_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .SCLK         (SCLK),
    .COPI         (COPI),
    .spi_cs_n     (spi_cs_n),
    .result_out   (result_out),
    .result_ready (result_ready),
    .send_image   (send_image),
    .status_ready (status_ready),
    .heartbeat    (heartbeat),
    .test_id      (test_id),
    .error_count  (chk_errors),
    .check_count  (chk_checks)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // One SCLK level, 4 to 7 clk cycles
  task automatic hold_level();
    repeat ($urandom_range(7, 4)) @(posedge clk);
  endtask

  // Data changes with the falling SCLK
  task automatic send_bit(input logic b);
    SCLK <= 1'b0;
    COPI <= b;
    hold_level();
    SCLK <= 1'b1;
    hold_level();
  endtask

  // MSB first
  task automatic send_byte(input logic [7:0] data);
    for (int i = 7; i >= 0; i--) begin
      send_bit(data[i]);
    end
  endtask

  task automatic begin_frame();
    spi_cs_n <= 1'b0;
    hold_level();
  endtask

  task automatic end_frame();
    SCLK <= 1'b0;
    hold_level();
    hold_level();
    spi_cs_n <= 1'b1;
    // Idle gap, FSM back in IDLE well before the next frame
    repeat ($urandom_range(20, 12)) @(posedge clk);
  endtask

  // Single command byte, random filler in the low nibble
  task automatic send_command(input logic [3:0] op);
    begin_frame();
    send_byte({op, 4'($urandom)});
    end_frame();
  endtask

  // Load frame, optionally cut off after a few bits of one more byte
  task automatic send_load(input int n_bytes, input int cut_bits);
    begin_frame();
    send_byte({`OP_LOAD, 4'($urandom)});
    for (int i = 0; i < n_bytes; i++) begin
      send_byte(8'($urandom));
    end
    for (int i = 0; i < cut_bits; i++) begin
      send_bit(1'($urandom));
    end
    end_frame();
  endtask

  // Result pins valid once status_ready comes back with result_ready
  task automatic wait_result();
    int cycles;
    cycles = 0;
    while (!(status_ready && result_ready) && cycles < RESULT_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (cycles >= RESULT_TIMEOUT) begin
      tb_errors++;
      $display("classification result did not arrive within %0d cycles", RESULT_TIMEOUT);
    end
  endtask

  task automatic classify_full();
    send_command(`OP_CLASSIFY);
    wait_result();
  endtask

  initial begin
    void'($urandom(32'h37ca_3eea));
    rst_n     = 1'b0;
    SCLK      = 1'b0;
    COPI      = 1'b0;
    spi_cs_n  = 1'b1;
    test_id   = 3'd1;
    tb_errors = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) @(posedge clk);
    // Full image, then classify
    test_id <= 3'd2;
    send_load(`IMG_BYTES, 0);
    classify_full();
    // Partial image, classify and an unknown opcode do nothing
    test_id <= 3'd3;
    send_command(`OP_CLEAR);
    send_load(40, 0);
    send_command(`OP_CLASSIFY);
    send_command(4'($urandom_range(15, 4)));
    // 140 bytes offered, last 27 dropped
    test_id <= 3'd4;
    send_load(100, 0);
    classify_full();
    // Clear, reload, classify twice
    test_id <= 3'd5;
    send_command(`OP_CLEAR);
    send_load(`IMG_BYTES, 0);
    classify_full();
    classify_full();
    // Frame cut mid-byte, remainder in a second frame
    test_id <= 3'd6;
    send_command(`OP_CLEAR);
    send_load(30, 3);
    send_load(`IMG_BYTES - 30, 0);
    classify_full();
    repeat (20) @(posedge clk);
    sva_fails = UUT.u_controller_fsm.u_fsm_sva.fail_count;
    $display("checks %0d, checker errors %0d, testbench errors %0d, assertion failures %0d",
             chk_checks, chk_errors, tb_errors, sva_fails);
    if (chk_errors + tb_errors + sva_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("simulation stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/bnn_interface.sv
`timescale 1ns/10ps
`default_nettype none

`include "bnn_params.svh"

module bnn_interface (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`IMG_BITS-1:0]    img_in,
  input  logic                    img_buffer_full,
  input  logic                    bnn_start,
  output bnn_pkg::class_result_s  result
);

  logic busy;
  // Last class finished, result goes out next cycle
  logic done;
  logic [3:0] cls;
  logic [`BUF_PTR_BITS-1:0] byte_idx;
  logic [`SCORE_BITS-1:0] score;
  logic [`SCORE_BITS-1:0] score_sum;
  logic [`SCORE_BITS-1:0] best_score;
  logic [3:0] best_idx;
  logic [7:0] img_byte;
  logic [7:0] w_byte;
  logic last_byte;
  logic last_class;

  // Fixed weights, one bit set means +1
  function automatic logic [7:0] weight_byte(input logic [6:0] idx, input logic [3:0] c);
    logic [15:0] mix;
    mix = 16'(idx) * 16'd37 + 16'(c) * 16'd101;
    return mix[7:0] ^ 8'h5A;
  endfunction

  function automatic logic [3:0] popcount8(input logic [7:0] bits);
    logic [3:0] total;
    total = '0;
    for (int k = 0; k < 8; k++) begin
      total = total + 4'(bits[k]);
    end
    return total;
  endfunction

  assign img_byte   = img_in[{byte_idx, 3'b000} +: 8];
  assign w_byte     = weight_byte(byte_idx, cls);
  // XNOR counts pixels that agree with the weight sign
  assign score_sum  = score + `SCORE_BITS'(popcount8(~(img_byte ^ w_byte)));
  assign last_byte  = (byte_idx == `BUF_PTR_BITS'(`IMG_BYTES - 1));
  assign last_class = (cls == 4'(`NUM_CLASSES - 1));

  // Sequencer, one image byte per cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy && bnn_start && img_buffer_full) begin
        busy <= 1'b1;
      end else if (busy && last_byte && last_class) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // Counters and scores
  always_ff @(posedge clk) begin
    if (!busy && bnn_start && img_buffer_full) begin
      cls        <= '0;
      byte_idx   <= '0;
      score      <= '0;
      best_score <= '0;
      best_idx   <= '0;
    end else if (busy) begin
      if (last_byte) begin
        byte_idx <= '0;
        score    <= '0;
        cls      <= cls + 4'd1;
        // Strictly higher only, so the lower index keeps a tie
        if (score_sum > best_score) begin
          best_score <= score_sum;
          best_idx   <= cls;
        end
      end else begin
        byte_idx <= byte_idx + `BUF_PTR_BITS'(1);
        score    <= score_sum;
      end
    end
  end

  // Answer, valid for one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result.valid     <= 1'b0;
      result.class_idx <= '0;
    end else begin
      result.valid <= done;
      if (done) begin
        result.class_idx <= best_idx;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/bnn_params.svh
`ifndef BNN_PARAMS_SVH
`define BNN_PARAMS_SVH

// Image geometry, one bit per pixel
`define IMG_BYTES 113
`define IMG_BITS (`IMG_BYTES * 8)

// Width of the buffer write pointer and byte count
`define BUF_PTR_BITS 7

// Output layer size
`define NUM_CLASSES 10

// Score holds up to 904 agreeing bits
`define SCORE_BITS 10

// Free-running counter, top bit drives the heartbeat pin
`define HEARTBEAT_BITS 12

// Opcodes in the upper nibble of the command byte
`define OP_LOAD 4'd1
`define OP_CLASSIFY 4'd2
`define OP_CLEAR 4'd3

`endif

// File: design/bnn_pkg.sv
`default_nettype none

package bnn_pkg;

  // Command view of the first byte in a frame
  typedef struct packed {
    logic [3:0] opcode;
    // Lower nibble carries nothing
    logic [3:0] rsvd;
  } cmd_s;

  // Same received byte, read as a command or as 8 pixels
  typedef union packed {
    cmd_s       cmd;
    logic [7:0] pixels;
  } spi_byte_u;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    CMD,
    LOAD,
    RUN,
    DONE
  } fsm_state_e;

  // Fill level of the image buffer
  typedef struct packed {
    logic       full;
    logic       empty;
    logic [6:0] count;
  } buf_status_s;

  // Winning class, valid pulses once per inference
  typedef struct packed {
    logic [3:0] class_idx;
    logic       valid;
  } class_result_s;

endpackage

`default_nettype wire

// File: design/controller_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "bnn_params.svh"

module controller_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    spi_cs_n,
  input  logic                    spi_byte_valid,
  input  bnn_pkg::spi_byte_u      spi_rx_data,
  input  bnn_pkg::buf_status_s    status,
  input  bnn_pkg::class_result_s  result,
  output logic                    rx_enable,
  output logic                    byte_taken,
  output logic                    buffer_write_enable,
  output logic                    clear_buffer,
  output logic                    bnn_start,
  output logic                    send_image,
  output logic                    status_ready,
  output logic                    result_ready,
  output logic                    heartbeat,
  output logic [3:0]              result_out,
  output bnn_pkg::fsm_state_e     fsm_state
);

  bnn_pkg::fsm_state_e state, next_state;
  logic cs_sync1, cs_sync2, cs_last;
  logic cs_fall, cs_rise;
  logic take_byte;
  logic [3:0] opcode;
  logic write_d, clear_d, start_d, result_ready_d;
  logic [`HEARTBEAT_BITS-1:0] hb_cnt;

  // Frame edges, same sync depth as the SPI receiver
  assign cs_fall   = cs_last & ~cs_sync2;
  assign cs_rise   = ~cs_last & cs_sync2;
  // Skip the cycle where the take pulse is already out
  assign take_byte = spi_byte_valid & ~byte_taken;
  assign opcode    = spi_rx_data.cmd.opcode;

  always_comb begin
    next_state     = state;
    write_d        = 1'b0;
    clear_d        = 1'b0;
    start_d        = 1'b0;
    result_ready_d = result_ready;
    case (state)
      bnn_pkg::IDLE: begin
        if (cs_fall) begin
          next_state = bnn_pkg::CMD;
        end
      end
      bnn_pkg::CMD: begin
        if (take_byte) begin
          case (opcode)
            `OP_LOAD: begin
              next_state     = bnn_pkg::LOAD;
              result_ready_d = 1'b0;
            end
            `OP_CLASSIFY: begin
              // Partial image, command dropped
              if (status.full) begin
                next_state = bnn_pkg::RUN;
                start_d    = 1'b1;
              end else begin
                next_state = bnn_pkg::IDLE;
              end
            end
            `OP_CLEAR: begin
              next_state     = bnn_pkg::IDLE;
              clear_d        = 1'b1;
              result_ready_d = 1'b0;
            end
            default: next_state = bnn_pkg::IDLE;
          endcase
        end else if (cs_rise) begin
          next_state = bnn_pkg::IDLE;
        end
      end
      bnn_pkg::LOAD: begin
        // Extra bytes past a full image are taken and dropped
        if (take_byte && !status.full) begin
          write_d = 1'b1;
        end
        if (cs_rise) begin
          next_state = bnn_pkg::IDLE;
        end
      end
      bnn_pkg::RUN: begin
        // Runs to the end regardless of chip select
        if (result.valid) begin
          next_state     = bnn_pkg::DONE;
          result_ready_d = 1'b1;
        end
      end
      bnn_pkg::DONE: next_state = bnn_pkg::IDLE;
      default: next_state = bnn_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state               <= bnn_pkg::IDLE;
      cs_sync1            <= 1'b1;
      cs_sync2            <= 1'b1;
      cs_last             <= 1'b1;
      byte_taken          <= 1'b0;
      buffer_write_enable <= 1'b0;
      clear_buffer        <= 1'b0;
      bnn_start           <= 1'b0;
      rx_enable           <= 1'b1;
      status_ready        <= 1'b1;
      send_image          <= 1'b1;
      result_ready        <= 1'b0;
      result_out          <= '0;
      hb_cnt              <= '0;
    end else begin
      state               <= next_state;
      cs_sync1            <= spi_cs_n;
      cs_sync2            <= cs_sync1;
      cs_last             <= cs_sync2;
      // Bytes in any state are drained, stale data never reaches CMD
      byte_taken          <= take_byte;
      buffer_write_enable <= write_d;
      clear_buffer        <= clear_d;
      bnn_start           <= start_d;
      // Receiver frozen during inference
      rx_enable           <= (next_state != bnn_pkg::RUN);
      status_ready        <= (next_state == bnn_pkg::IDLE) || (next_state == bnn_pkg::DONE);
      send_image          <= (next_state == bnn_pkg::IDLE) && status.empty;
      result_ready        <= result_ready_d;
      if (state == bnn_pkg::RUN && result.valid) begin
        result_out <= result.class_idx;
      end
      hb_cnt <= hb_cnt + `HEARTBEAT_BITS'(1);
    end
  end

  assign heartbeat = hb_cnt[`HEARTBEAT_BITS-1];
  assign fsm_state = state;

endmodule

`default_nettype wire

// File: design/image_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "bnn_params.svh"

module image_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clear_buffer,
  input  logic                  write_enable,
  input  bnn_pkg::spi_byte_u    data_in,
  output bnn_pkg::buf_status_s  status,
  output logic [`IMG_BITS-1:0]  img_out
);

  logic [7:0] mem [`IMG_BYTES];
  // Next free byte, doubles as the fill count
  logic [`BUF_PTR_BITS-1:0] wr_ptr;
  logic buf_full;

  assign buf_full = (wr_ptr == `BUF_PTR_BITS'(`IMG_BYTES));

  // Pointer stops at the image length
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (clear_buffer) begin
      wr_ptr <= '0;
    end else if (write_enable && !buf_full) begin
      wr_ptr <= wr_ptr + `BUF_PTR_BITS'(1);
    end
  end

  // Byte storage, wiped by clear
  always_ff @(posedge clk) begin
    if (clear_buffer) begin
      for (int i = 0; i < `IMG_BYTES; i++) begin
        mem[i] <= 8'h00;
      end
    end else if (write_enable && !buf_full) begin
      mem[wr_ptr] <= data_in.pixels;
    end
  end

  // Status follows the pointer register, one cycle after a write
  assign status.full  = buf_full;
  assign status.empty = (wr_ptr == '0);
  assign status.count = wr_ptr;

  // Byte 0 at the lowest bits
  always_comb begin
    for (int i = 0; i < `IMG_BYTES; i++) begin
      img_out[i*8 +: 8] = mem[i];
    end
  end

endmodule

`default_nettype wire

// File: design/spi_peripheral.sv
`timescale 1ns/10ps
`default_nettype none

module spi_peripheral (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                SCLK,
  input  logic                COPI,
  input  logic                spi_cs_n,
  input  logic                rx_enable,
  input  logic                byte_taken,
  output bnn_pkg::spi_byte_u  spi_rx_data,
  output logic                spi_byte_valid
);

  // Two-flop synchronizers for the three pins
  logic sclk_sync1, sclk_sync2, sclk_last;
  logic copi_sync1, copi_sync2;
  logic cs_sync1, cs_sync2;
  logic sclk_rise;
  logic shift_now;
  logic [2:0] bit_cnt;
  logic [7:0] shift_reg;
  logic [7:0] next_byte;

  // Rising SCLK seen after synchronization
  assign sclk_rise = sclk_sync2 & ~sclk_last;
  // Shift only inside a frame and while the FSM accepts data
  assign shift_now = sclk_rise & rx_enable & ~cs_sync2;
  // MSB first, new bit enters at the bottom
  assign next_byte = {shift_reg[6:0], copi_sync2};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sclk_sync1 <= 1'b0;
      sclk_sync2 <= 1'b0;
      sclk_last  <= 1'b0;
      copi_sync1 <= 1'b0;
      copi_sync2 <= 1'b0;
      // Chip select idles high
      cs_sync1   <= 1'b1;
      cs_sync2   <= 1'b1;
    end else begin
      sclk_sync1 <= SCLK;
      sclk_sync2 <= sclk_sync1;
      sclk_last  <= sclk_sync2;
      copi_sync1 <= COPI;
      copi_sync2 <= copi_sync1;
      cs_sync1   <= spi_cs_n;
      cs_sync2   <= cs_sync1;
    end
  end

  // Bit counter and valid flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt        <= '0;
      spi_byte_valid <= 1'b0;
    end else begin
      if (byte_taken) begin
        spi_byte_valid <= 1'b0;
      end
      if (cs_sync2) begin
        // Partial byte dropped between frames
        bit_cnt <= '0;
      end else if (shift_now) begin
        bit_cnt <= bit_cnt + 3'd1;
        // Set wins over a take in the same cycle
        if (bit_cnt == 3'd7) begin
          spi_byte_valid <= 1'b1;
        end
      end
    end
  end

  // Shift register and holding register
  always_ff @(posedge clk) begin
    if (shift_now) begin
      shift_reg <= next_byte;
      if (bit_cnt == 3'd7) begin
        spi_rx_data.pixels <= next_byte;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/system_controller.sv
`timescale 1ns/10ps
`default_nettype none

`include "bnn_params.svh"

module system_controller (
  input  logic       clk,
  input  logic       rst_n,
  // SPI pins
  input  logic       SCLK,
  input  logic       COPI,
  input  logic       spi_cs_n,
  // Class index of the last inference
  output logic [3:0] result_out,
  // Status pins
  output logic       result_ready,
  output logic       send_image,
  output logic       status_ready,
  output logic       heartbeat
);

  // SPI receiver to controller
  bnn_pkg::spi_byte_u     spi_rx_data;
  logic                   spi_byte_valid;
  logic                   byte_taken;
  logic                   rx_enable;
  // Controller to buffer
  logic                   buffer_write_enable;
  logic                   clear_buffer;
  bnn_pkg::buf_status_s   buf_status;
  // Buffer to core
  logic [`IMG_BITS-1:0]   image_flat;
  // Core handshake
  logic                   bnn_start;
  bnn_pkg::class_result_s class_result;
  // Observed by the bound checks only
  bnn_pkg::fsm_state_e    fsm_state;

  controller_fsm u_controller_fsm (
    .clk                 (clk),
    .rst_n               (rst_n),
    .spi_cs_n            (spi_cs_n),
    .spi_byte_valid      (spi_byte_valid),
    .spi_rx_data         (spi_rx_data),
    .status              (buf_status),
    .result              (class_result),
    .rx_enable           (rx_enable),
    .byte_taken          (byte_taken),
    .buffer_write_enable (buffer_write_enable),
    .clear_buffer        (clear_buffer),
    .bnn_start           (bnn_start),
    .send_image          (send_image),
    .status_ready        (status_ready),
    .result_ready        (result_ready),
    .heartbeat           (heartbeat),
    .result_out          (result_out),
    .fsm_state           (fsm_state)
  );

  spi_peripheral u_spi_peripheral (
    .clk            (clk),
    .rst_n          (rst_n),
    .SCLK           (SCLK),
    .COPI           (COPI),
    .spi_cs_n       (spi_cs_n),
    .rx_enable      (rx_enable),
    .byte_taken     (byte_taken),
    .spi_rx_data    (spi_rx_data),
    .spi_byte_valid (spi_byte_valid)
  );

  image_buffer u_image_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_buffer (clear_buffer),
    .write_enable (buffer_write_enable),
    .data_in      (spi_rx_data),
    .status       (buf_status),
    .img_out      (image_flat)
  );

  bnn_interface u_bnn_interface (
    .clk             (clk),
    .rst_n           (rst_n),
    .img_in          (image_flat),
    .img_buffer_full (buf_status.full),
    .bnn_start       (bnn_start),
    .result          (class_result)
  );

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/bnn_pkg.sv
design/spi_peripheral.sv
design/image_buffer.sv
design/bnn_interface.sv
design/controller_fsm.sv
design/system_controller.sv
bench/result_checker.sv
bench/system_controller_sva.sv
bench/system_controller_tb.sv
